/* Makefile */
TOP := tb_rvfi_checker

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module $(TOP)

sim:
	verilator --binary --assert -Wno-fatal -j 0 -f project.f --top-module $(TOP)
	./obj_dir/V$(TOP) | awk '{ print } /ALL TESTS PASSED/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* hdl/check_control.sv */
`default_nettype none

module check_control
	import rvfi_check_pkg::*;
(
	input  wire               clk,
	input  wire               rst_n,
	input  wire               fault_valid,
	input  wire check_fault_t fault,
	output logic              check_done,
	output check_fault_t      check_fault,
	output count_t            retire_count,
	output count_t            fault_count
);

	check_state_t state;
	check_state_t state_next;

	// active for exactly the cycles that present a result; back to back results
	// keep the machine in active.
	always_comb begin
		if (fault_valid)
			state_next = active;
		else
			state_next = idle;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state        <= idle;
			check_fault  <= fault_none;
			retire_count <= '0;
			fault_count  <= '0;
		end else begin
			state <= state_next;
			if (fault_valid) begin
				check_fault <= fault;
				// both counters stop at their maximum.
				if (retire_count != '1)
					retire_count <= retire_count + 1'b1;
				if (fault != fault_none && fault_count != '1)
					fault_count <= fault_count + 1'b1;
			end
		end
	end

	assign check_done = (state == active);

endmodule

`default_nettype wire

/* hdl/insn_spec_alu.sv */
`default_nettype none

module insn_spec_alu
	import rvfi_check_pkg::*;
(
	input  wire insn_t     insn,
	input  wire xlen_t     rs1_rdata,
	input  wire xlen_t     rs2_rdata,
	input  wire xlen_t     pc_rdata,
	output logic           claim,
	output reg_addr_t      spec_rs1_addr,
	output reg_addr_t      spec_rs2_addr,
	output reg_addr_t      spec_rd_addr,
	output xlen_t          spec_rd_wdata,
	output xlen_t          spec_pc_wdata
);

	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_lui    = 7'b0110111;

	// five staged right shift; each stage moves by a power of two.
	function automatic xlen_t shift_right(input xlen_t value, input logic [4:0] amount,
			input logic fill);
		xlen_t result;
		xlen_t fill_mask;
		result = value;
		for (int s = 0; s < 5; s++) begin
			fill_mask = ~(xlen_t'('1) >> (1 << s));
			if (amount[s])
				result = (result >> (1 << s)) | (fill ? fill_mask : xlen_t'(0));
		end
		return result;
	endfunction

	function automatic xlen_t reverse(input xlen_t value);
		xlen_t result;
		for (int b = 0; b < $bits(xlen_t); b++)
			result[b] = value[$bits(xlen_t)-1-b];
		return result;
	endfunction

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       is_op_imm;
	logic       is_op;
	logic       is_lui;
	logic [4:0] shamt;
	xlen_t      imm_i;
	xlen_t      op_b;
	xlen_t      result;

	assign opcode = insn[6:0];
	assign funct3 = insn[14:12];
	assign funct7 = insn[31:25];

	assign is_op_imm = (opcode == opc_op_imm);
	assign is_op     = (opcode == opc_op);
	assign is_lui    = (opcode == opc_lui);

	assign imm_i = xlen_t'($signed(insn[31:20]));
	assign op_b  = is_op ? rs2_rdata : imm_i;
	assign shamt = op_b[4:0];

	// shifts and OP take funct7 as an opcode extension, so only two values are legal.
	always_comb begin
		claim = 1'b0;
		if (is_lui)
			claim = 1'b1;
		else if (is_op_imm)
			claim = (funct3 == 3'b001) ? (funct7 == 7'b0000000) :
				(funct3 == 3'b101) ? (funct7 == 7'b0000000 || funct7 == 7'b0100000) : 1'b1;
		else if (is_op)
			claim = (funct7 == 7'b0000000) ||
				(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
	end

	always_comb begin
		case (funct3)
			3'b000: result = (is_op && funct7[5]) ? rs1_rdata - op_b : rs1_rdata + op_b;
			3'b001: result = reverse(shift_right(reverse(rs1_rdata), shamt, 1'b0));
			3'b010: result = xlen_t'($signed(rs1_rdata) < $signed(op_b));
			3'b011: result = xlen_t'(rs1_rdata < op_b);
			3'b100: result = rs1_rdata ^ op_b;
			3'b101: result = shift_right(rs1_rdata, shamt, funct7[5] & rs1_rdata[31]);
			3'b110: result = rs1_rdata | op_b;
			default: result = rs1_rdata & op_b;
		endcase
		if (is_lui)
			result = {insn[31:12], 12'b0};
	end

	assign spec_rs1_addr = is_lui ? reg_addr_t'(0) : insn[19:15];
	assign spec_rs2_addr = is_op ? insn[24:20] : reg_addr_t'(0);
	assign spec_rd_addr  = insn[11:7];
	assign spec_rd_wdata = (spec_rd_addr != 5'd0) ? result : xlen_t'(0);
	assign spec_pc_wdata = pc_rdata + xlen_t'(4);

endmodule

`default_nettype wire

/* hdl/insn_spec_mem.sv */
`default_nettype none

module insn_spec_mem
	import rvfi_check_pkg::*;
(
	input  wire insn_t     insn,
	input  wire xlen_t     rs1_rdata,
	input  wire xlen_t     rs2_rdata,
	input  wire xlen_t     pc_rdata,
	input  wire xlen_t     mem_rdata,
	output logic           claim,
	output logic           spec_trap,
	output reg_addr_t      spec_rs1_addr,
	output reg_addr_t      spec_rs2_addr,
	output reg_addr_t      spec_rd_addr,
	output xlen_t          spec_rd_wdata,
	output xlen_t          spec_pc_wdata,
	output xlen_t          spec_mem_addr,
	output byte_mask_t     spec_mem_rmask,
	output byte_mask_t     spec_mem_wmask,
	output xlen_t          spec_mem_wdata
);

	logic  is_lw;
	logic  is_sw;
	logic  misaligned;
	xlen_t imm;
	xlen_t addr;

	assign is_lw = (insn[6:0] == 7'b0000011) && (insn[14:12] == 3'b010);
	assign is_sw = (insn[6:0] == 7'b0100011) && (insn[14:12] == 3'b010);

	// stores split the immediate around the rs2 field.
	assign imm = is_sw ? xlen_t'($signed({insn[31:25], insn[11:7]})) :
		xlen_t'($signed(insn[31:20]));
	assign addr = rs1_rdata + imm;
	assign misaligned = (addr[1:0] != 2'b00);

	assign claim     = is_lw | is_sw;
	assign spec_trap = misaligned;

	assign spec_rs1_addr = insn[19:15];
	assign spec_rs2_addr = is_sw ? insn[24:20] : reg_addr_t'(0);

	// a load that traps writes no register.
	assign spec_rd_addr  = (is_lw && !misaligned) ? insn[11:7] : reg_addr_t'(0);
	assign spec_rd_wdata = (spec_rd_addr != 5'd0) ? mem_rdata : xlen_t'(0);
	assign spec_pc_wdata = pc_rdata + xlen_t'(4);

	assign spec_mem_addr  = addr;
	assign spec_mem_rmask = (is_lw && !misaligned) ? '1 : '0;
	assign spec_mem_wmask = (is_sw && !misaligned) ? '1 : '0;
	assign spec_mem_wdata = rs2_rdata;

endmodule

`default_nettype wire

/* hdl/retire_compare.sv */
`default_nettype none

`include "rvfi_check_params.svh"

module retire_compare
	import rvfi_check_pkg::*;
(
	input  wire             clk,
	input  wire             rst_n,
	input  wire             rvfi_valid,
	input  wire             rvfi_trap,
	input  wire reg_addr_t  rvfi_rs1_addr,
	input  wire reg_addr_t  rvfi_rs2_addr,
	input  wire reg_addr_t  rvfi_rd_addr,
	input  wire xlen_t      rvfi_rd_wdata,
	input  wire xlen_t      rvfi_pc_wdata,
	input  wire xlen_t      rvfi_mem_addr,
	input  wire byte_mask_t rvfi_mem_rmask,
	input  wire byte_mask_t rvfi_mem_wmask,
	input  wire xlen_t      rvfi_mem_rdata,
	input  wire xlen_t      rvfi_mem_wdata,
	input  wire             alu_claim,
	input  wire reg_addr_t  alu_rs1_addr,
	input  wire reg_addr_t  alu_rs2_addr,
	input  wire reg_addr_t  alu_rd_addr,
	input  wire xlen_t      alu_rd_wdata,
	input  wire xlen_t      alu_pc_wdata,
	input  wire             mem_claim,
	input  wire             mem_trap,
	input  wire reg_addr_t  mem_rs1_addr,
	input  wire reg_addr_t  mem_rs2_addr,
	input  wire reg_addr_t  mem_rd_addr,
	input  wire xlen_t      mem_rd_wdata,
	input  wire xlen_t      mem_pc_wdata,
	input  wire xlen_t      mem_mem_addr,
	input  wire byte_mask_t mem_mem_rmask,
	input  wire byte_mask_t mem_mem_wmask,
	input  wire xlen_t      mem_mem_wdata,
	output logic            fault_valid,
	output check_fault_t    fault
);

	logic         spec_trap;
	reg_addr_t    spec_rs1_addr;
	reg_addr_t    spec_rs2_addr;
	reg_addr_t    spec_rd_addr;
	xlen_t        spec_rd_wdata;
	xlen_t        spec_pc_wdata;
	xlen_t        spec_mem_addr;
	byte_mask_t   spec_mem_rmask;
	byte_mask_t   spec_mem_wmask;
	xlen_t        spec_mem_wdata;
	logic         lane_wmask_bad;
	logic         lane_wdata_bad;
	logic         lane_rmask_bad;
	logic         body_checked;
	check_fault_t fault_next;

	// ########################################################################
	// spec select. an encoding no model claims is specified as a trap.
	// ########################################################################

	always_comb begin
		spec_trap      = 1'b1;
		spec_rs1_addr  = '0;
		spec_rs2_addr  = '0;
		spec_rd_addr   = '0;
		spec_rd_wdata  = '0;
		spec_pc_wdata  = '0;
		spec_mem_addr  = '0;
		spec_mem_rmask = '0;
		spec_mem_wmask = '0;
		spec_mem_wdata = '0;
		if (alu_claim) begin
			spec_trap     = 1'b0;
			spec_rs1_addr = alu_rs1_addr;
			spec_rs2_addr = alu_rs2_addr;
			spec_rd_addr  = alu_rd_addr;
			spec_rd_wdata = alu_rd_wdata;
			spec_pc_wdata = alu_pc_wdata;
		end else if (mem_claim) begin
			spec_trap      = mem_trap;
			spec_rs1_addr  = mem_rs1_addr;
			spec_rs2_addr  = mem_rs2_addr;
			spec_rd_addr   = mem_rd_addr;
			spec_rd_wdata  = mem_rd_wdata;
			spec_pc_wdata  = mem_pc_wdata;
			spec_mem_addr  = mem_mem_addr;
			spec_mem_rmask = mem_mem_rmask;
			spec_mem_wmask = mem_mem_wmask;
			spec_mem_wdata = mem_mem_wdata;
		end
	end

	// ########################################################################
	// byte lane rules.
	// ########################################################################

	always_comb begin
		lane_wmask_bad = 1'b0;
		lane_wdata_bad = 1'b0;
		lane_rmask_bad = 1'b0;
		for (int i = 0; i < `RVFI_XLEN/8; i++) begin
			if (spec_mem_wmask[i]) begin
				if (!rvfi_mem_wmask[i])
					lane_wmask_bad = 1'b1;
				if (spec_mem_wdata[i*8 +: 8] != rvfi_mem_wdata[i*8 +: 8])
					lane_wdata_bad = 1'b1;
			end else if (rvfi_mem_wmask[i]) begin
				// an extra core write is fine if it rewrites the byte it read.
				if (!rvfi_mem_rmask[i])
					lane_rmask_bad = 1'b1;
				if (rvfi_mem_rdata[i*8 +: 8] != rvfi_mem_wdata[i*8 +: 8])
					lane_wdata_bad = 1'b1;
			end
			if (spec_mem_rmask[i] && !rvfi_mem_rmask[i])
				lane_rmask_bad = 1'b1;
		end
	end

	// rd and pc results are only specified for an instruction that retires cleanly.
	assign body_checked = !spec_trap;

	always_comb begin
		fault_next = fault_none;
		if (spec_rs1_addr != 5'd0 && spec_rs1_addr != rvfi_rs1_addr)
			fault_next = fault_rs1;
		else if (spec_rs2_addr != 5'd0 && spec_rs2_addr != rvfi_rs2_addr)
			fault_next = fault_rs2;
		else if (body_checked && spec_rd_addr != rvfi_rd_addr)
			fault_next = fault_rd_addr;
		else if (body_checked && spec_rd_wdata != rvfi_rd_wdata)
			fault_next = fault_rd_wdata;
		else if (body_checked && spec_pc_wdata != rvfi_pc_wdata)
			fault_next = fault_pc;
		else if (((|spec_mem_rmask) || (|spec_mem_wmask)) &&
				spec_mem_addr != rvfi_mem_addr)
			fault_next = fault_mem_addr;
		else if (lane_wmask_bad)
			fault_next = fault_mem_wmask;
		else if (lane_wdata_bad)
			fault_next = fault_mem_wdata;
		else if (lane_rmask_bad)
			fault_next = fault_mem_rmask;
		else if (spec_trap != rvfi_trap)
			fault_next = fault_trap;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fault_valid <= 1'b0;
			fault       <= fault_none;
		end else begin
			fault_valid <= rvfi_valid;
			if (rvfi_valid)
				fault <= fault_next;
		end
	end

endmodule

`default_nettype wire

/* hdl/rvfi_check_pkg.sv */
`default_nettype none

`include "rvfi_check_params.svh"

package rvfi_check_pkg;

	typedef logic [`RVFI_XLEN-1:0] xlen_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [`RVFI_XLEN/8-1:0] byte_mask_t;
	typedef logic [31:0] insn_t;
	typedef logic [`RVFI_COUNT_W-1:0] count_t;

	// the encoding order is also the reporting priority, lowest code first.
	typedef enum logic [3:0] {
		fault_none,
		fault_rs1,
		fault_rs2,
		fault_rd_addr,
		fault_rd_wdata,
		fault_pc,
		fault_mem_addr,
		fault_mem_wmask,
		fault_mem_wdata,
		fault_mem_rmask,
		fault_trap
	} check_fault_t;

	typedef enum logic {
		idle,
		active
	} check_state_t;

endpackage

`default_nettype wire

/* hdl/rvfi_checker.sv */
`default_nettype none

module rvfi_checker
	import rvfi_check_pkg::*;
(
	input  wire             clk,
	input  wire             rst_n,
	input  wire             rvfi_valid,
	input  wire insn_t      rvfi_insn,
	input  wire             rvfi_trap,
	input  wire reg_addr_t  rvfi_rs1_addr,
	input  wire reg_addr_t  rvfi_rs2_addr,
	input  wire xlen_t      rvfi_rs1_rdata,
	input  wire xlen_t      rvfi_rs2_rdata,
	input  wire reg_addr_t  rvfi_rd_addr,
	input  wire xlen_t      rvfi_rd_wdata,
	input  wire xlen_t      rvfi_pc_rdata,
	input  wire xlen_t      rvfi_pc_wdata,
	input  wire xlen_t      rvfi_mem_addr,
	input  wire byte_mask_t rvfi_mem_rmask,
	input  wire byte_mask_t rvfi_mem_wmask,
	input  wire xlen_t      rvfi_mem_rdata,
	input  wire xlen_t      rvfi_mem_wdata,
	output logic            check_done,
	output check_fault_t    check_fault,
	output count_t          retire_count,
	output count_t          fault_count
);

	logic         alu_claim;
	reg_addr_t    alu_rs1_addr;
	reg_addr_t    alu_rs2_addr;
	reg_addr_t    alu_rd_addr;
	xlen_t        alu_rd_wdata;
	xlen_t        alu_pc_wdata;
	logic         mem_claim;
	logic         mem_trap;
	reg_addr_t    mem_rs1_addr;
	reg_addr_t    mem_rs2_addr;
	reg_addr_t    mem_rd_addr;
	xlen_t        mem_rd_wdata;
	xlen_t        mem_pc_wdata;
	xlen_t        mem_mem_addr;
	byte_mask_t   mem_mem_rmask;
	byte_mask_t   mem_mem_wmask;
	xlen_t        mem_mem_wdata;
	logic         fault_valid;
	check_fault_t fault;

	// ########################################################################
	// reference models, both fed from the raw trace.
	// ########################################################################

	insn_spec_alu u_spec_alu (
		.insn          (rvfi_insn),
		.rs1_rdata     (rvfi_rs1_rdata),
		.rs2_rdata     (rvfi_rs2_rdata),
		.pc_rdata      (rvfi_pc_rdata),
		.claim         (alu_claim),
		.spec_rs1_addr (alu_rs1_addr),
		.spec_rs2_addr (alu_rs2_addr),
		.spec_rd_addr  (alu_rd_addr),
		.spec_rd_wdata (alu_rd_wdata),
		.spec_pc_wdata (alu_pc_wdata)
	);

	insn_spec_mem u_spec_mem (
		.insn           (rvfi_insn),
		.rs1_rdata      (rvfi_rs1_rdata),
		.rs2_rdata      (rvfi_rs2_rdata),
		.pc_rdata       (rvfi_pc_rdata),
		.mem_rdata      (rvfi_mem_rdata),
		.claim          (mem_claim),
		.spec_trap      (mem_trap),
		.spec_rs1_addr  (mem_rs1_addr),
		.spec_rs2_addr  (mem_rs2_addr),
		.spec_rd_addr   (mem_rd_addr),
		.spec_rd_wdata  (mem_rd_wdata),
		.spec_pc_wdata  (mem_pc_wdata),
		.spec_mem_addr  (mem_mem_addr),
		.spec_mem_rmask (mem_mem_rmask),
		.spec_mem_wmask (mem_mem_wmask),
		.spec_mem_wdata (mem_mem_wdata)
	);

	// ########################################################################
	// compare stage and result control.
	// ########################################################################

	retire_compare u_compare (
		.clk            (clk),
		.rst_n          (rst_n),
		.rvfi_valid     (rvfi_valid),
		.rvfi_trap      (rvfi_trap),
		.rvfi_rs1_addr  (rvfi_rs1_addr),
		.rvfi_rs2_addr  (rvfi_rs2_addr),
		.rvfi_rd_addr   (rvfi_rd_addr),
		.rvfi_rd_wdata  (rvfi_rd_wdata),
		.rvfi_pc_wdata  (rvfi_pc_wdata),
		.rvfi_mem_addr  (rvfi_mem_addr),
		.rvfi_mem_rmask (rvfi_mem_rmask),
		.rvfi_mem_wmask (rvfi_mem_wmask),
		.rvfi_mem_rdata (rvfi_mem_rdata),
		.rvfi_mem_wdata (rvfi_mem_wdata),
		.alu_claim      (alu_claim),
		.alu_rs1_addr   (alu_rs1_addr),
		.alu_rs2_addr   (alu_rs2_addr),
		.alu_rd_addr    (alu_rd_addr),
		.alu_rd_wdata   (alu_rd_wdata),
		.alu_pc_wdata   (alu_pc_wdata),
		.mem_claim      (mem_claim),
		.mem_trap       (mem_trap),
		.mem_rs1_addr   (mem_rs1_addr),
		.mem_rs2_addr   (mem_rs2_addr),
		.mem_rd_addr    (mem_rd_addr),
		.mem_rd_wdata   (mem_rd_wdata),
		.mem_pc_wdata   (mem_pc_wdata),
		.mem_mem_addr   (mem_mem_addr),
		.mem_mem_rmask  (mem_mem_rmask),
		.mem_mem_wmask  (mem_mem_wmask),
		.mem_mem_wdata  (mem_mem_wdata),
		.fault_valid    (fault_valid),
		.fault          (fault)
	);

	check_control u_control (
		.clk          (clk),
		.rst_n        (rst_n),
		.fault_valid  (fault_valid),
		.fault        (fault),
		.check_done   (check_done),
		.check_fault  (check_fault),
		.retire_count (retire_count),
		.fault_count  (fault_count)
	);

endmodule

`default_nettype wire

/* include/rvfi_check_params.svh */
`ifndef RVFI_CHECK_PARAMS_SVH
`define RVFI_CHECK_PARAMS_SVH

// width of a data word and of an address on the traced core.
`define RVFI_XLEN 32

// width of the retirement and fault counters.
`define RVFI_COUNT_W 16

`endif

/* project.f */
+incdir+include
hdl/rvfi_check_pkg.sv
hdl/insn_spec_alu.sv
hdl/insn_spec_mem.sv
hdl/retire_compare.sv
hdl/check_control.sv
hdl/rvfi_checker.sv
test/tb_clock.sv
test/rvfi_checker_asserts.sv
test/tb_rvfi_checker.sv

/* test/rvfi_checker_asserts.sv */
`default_nettype none

module rvfi_checker_asserts
	import rvfi_check_pkg::*;
(
	input wire         clk,
	input wire         rst_n,
	input wire         rvfi_valid,
	input wire         check_done,
	input wire count_t retire_count
);

	// every strobe produces its result exactly two cycles later.
	done_after_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rvfi_valid, 2) |-> check_done)
		else $error("check_done did not follow a strobe by two cycles");

	// a result without a strobe two cycles earlier is spurious.
	no_done_without_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		!$past(rvfi_valid, 2) |-> !check_done)
		else $error("check_done pulsed without a strobe");

	retire_count_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
		retire_count >= $past(retire_count))
		else $error("retire_count decreased");

endmodule

bind rvfi_checker rvfi_checker_asserts u_asserts (
	.clk          (clk),
	.rst_n        (rst_n),
	.rvfi_valid   (rvfi_valid),
	.check_done   (check_done),
	.retire_count (retire_count)
);

`default_nettype wire

/* test/tb_clock.sv */
`default_nettype none

module tb_clock #(
	parameter int period = 40
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

/* test/tb_rvfi_checker.sv */
`default_nettype none

module tb_rvfi_checker
	import rvfi_check_pkg::*;
();

	localparam int done_timeout = 20;

	typedef struct packed {
		insn_t      insn;
		logic       trap;
		reg_addr_t  rs1_addr;
		reg_addr_t  rs2_addr;
		xlen_t      rs1_rdata;
		xlen_t      rs2_rdata;
		reg_addr_t  rd_addr;
		xlen_t      rd_wdata;
		xlen_t      pc_rdata;
		xlen_t      pc_wdata;
		xlen_t      mem_addr;
		byte_mask_t rmask;
		byte_mask_t wmask;
		xlen_t      mem_rdata;
		xlen_t      mem_wdata;
	} trace_t;

	wire          clk;
	logic         rst_n;
	logic         rvfi_valid;
	insn_t        rvfi_insn;
	logic         rvfi_trap;
	reg_addr_t    rvfi_rs1_addr;
	reg_addr_t    rvfi_rs2_addr;
	xlen_t        rvfi_rs1_rdata;
	xlen_t        rvfi_rs2_rdata;
	reg_addr_t    rvfi_rd_addr;
	xlen_t        rvfi_rd_wdata;
	xlen_t        rvfi_pc_rdata;
	xlen_t        rvfi_pc_wdata;
	xlen_t        rvfi_mem_addr;
	byte_mask_t   rvfi_mem_rmask;
	byte_mask_t   rvfi_mem_wmask;
	xlen_t        rvfi_mem_rdata;
	xlen_t        rvfi_mem_wdata;
	logic         check_done;
	check_fault_t check_fault;
	count_t       retire_count;
	count_t       fault_count;
	integer       seed;
	count_t       exp_retire;
	count_t       exp_faults;

	tb_clock u_clock (
		.clk (clk)
	);

	rvfi_checker dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.rvfi_valid     (rvfi_valid),
		.rvfi_insn      (rvfi_insn),
		.rvfi_trap      (rvfi_trap),
		.rvfi_rs1_addr  (rvfi_rs1_addr),
		.rvfi_rs2_addr  (rvfi_rs2_addr),
		.rvfi_rs1_rdata (rvfi_rs1_rdata),
		.rvfi_rs2_rdata (rvfi_rs2_rdata),
		.rvfi_rd_addr   (rvfi_rd_addr),
		.rvfi_rd_wdata  (rvfi_rd_wdata),
		.rvfi_pc_rdata  (rvfi_pc_rdata),
		.rvfi_pc_wdata  (rvfi_pc_wdata),
		.rvfi_mem_addr  (rvfi_mem_addr),
		.rvfi_mem_rmask (rvfi_mem_rmask),
		.rvfi_mem_wmask (rvfi_mem_wmask),
		.rvfi_mem_rdata (rvfi_mem_rdata),
		.rvfi_mem_wdata (rvfi_mem_wdata),
		.check_done     (check_done),
		.check_fault    (check_fault),
		.retire_count   (retire_count),
		.fault_count    (fault_count)
	);

	// ########################################################################
	// trace construction from the instruction set rules.
	// ########################################################################

	function automatic xlen_t rnd_word();
		return xlen_t'($random(seed));
	endfunction

	// x0 is avoided so that every result is really written.
	function automatic reg_addr_t rnd_reg();
		return 5'd1 + reg_addr_t'($unsigned($random(seed)) % 31);
	endfunction

	function automatic xlen_t alu_expect(input logic [2:0] f3, input logic alt,
			input xlen_t a, input xlen_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return xlen_t'($signed(a) < $signed(b));
			3'd3: return xlen_t'(a < b);
			3'd4: return a ^ b;
			3'd5: return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic trace_t base_trace();
		trace_t t;
		t = '0;
		t.pc_rdata = rnd_word() & ~xlen_t'(3);
		t.pc_wdata = t.pc_rdata + xlen_t'(4);
		return t;
	endfunction

	function automatic trace_t alu_trace(input logic [2:0] f3, input logic alt,
			input logic is_imm);
		trace_t     t;
		xlen_t      tmp;
		logic [11:0] imm;
		xlen_t      operand_b;
		t = base_trace();
		t.rs1_addr = rnd_reg();
		t.rd_addr = rnd_reg();
		t.rs1_rdata = rnd_word();
		tmp = rnd_word();
		imm = tmp[11:0];
		// immediate shifts carry their funct7 in the upper immediate bits.
		if (f3 == 3'd1 || f3 == 3'd5)
			imm[11:5] = alt ? 7'b0100000 : 7'b0000000;
		if (is_imm) begin
			t.insn = {imm, t.rs1_addr, f3, t.rd_addr, 7'b0010011};
			operand_b = {{20{imm[11]}}, imm};
		end else begin
			t.rs2_addr = rnd_reg();
			t.rs2_rdata = rnd_word();
			t.insn = {alt ? 7'b0100000 : 7'b0000000, t.rs2_addr, t.rs1_addr, f3,
				t.rd_addr, 7'b0110011};
			operand_b = t.rs2_rdata;
		end
		t.rd_wdata = alu_expect(f3, alt, t.rs1_rdata, operand_b);
		return t;
	endfunction

	function automatic trace_t lui_trace();
		trace_t t;
		xlen_t  tmp;
		t = base_trace();
		t.rd_addr = rnd_reg();
		tmp = rnd_word();
		t.insn = {tmp[31:12], t.rd_addr, 7'b0110111};
		t.rd_wdata = {tmp[31:12], 12'h000};
		return t;
	endfunction

	function automatic trace_t mem_trace(input logic is_store, input logic misalign);
		trace_t      t;
		xlen_t       tmp;
		logic [11:0] imm;
		xlen_t       addr;
		t = base_trace();
		tmp = rnd_word();
		imm = {tmp[11:2], 2'b00};
		t.rs1_addr = rnd_reg();
		t.rs1_rdata = (rnd_word() & ~xlen_t'(3)) | xlen_t'(misalign);
		addr = t.rs1_rdata + {{20{imm[11]}}, imm};
		if (is_store) begin
			t.rs2_addr = rnd_reg();
			t.rs2_rdata = rnd_word();
			t.insn = {imm[11:5], t.rs2_addr, t.rs1_addr, 3'b010, imm[4:0], 7'b0100011};
			if (!misalign) begin
				t.mem_addr = addr;
				t.wmask = '1;
				t.mem_wdata = t.rs2_rdata;
			end
		end else begin
			t.rd_addr = rnd_reg();
			t.insn = {imm, t.rs1_addr, 3'b010, t.rd_addr, 7'b0000011};
			if (!misalign) begin
				t.mem_addr = addr;
				t.rmask = '1;
				t.mem_rdata = rnd_word();
				t.rd_wdata = t.mem_rdata;
			end
		end
		t.trap = misalign;
		return t;
	endfunction

	// an OP encoding with funct7 of the multiply extension, which the base set lacks.
	function automatic trace_t illegal_trace();
		trace_t t;
		t = alu_trace(3'd0, 1'b0, 1'b0);
		t.insn[31:25] = 7'b0000001;
		t.trap = 1'b1;
		return t;
	endfunction

	// ########################################################################
	// driving, waiting and comparing.
	// ########################################################################

	task automatic fail_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic compare_fault(input string name, input check_fault_t expected,
			input check_fault_t actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %s, actual %s", name, expected.name(),
				actual.name());
			fail_run();
		end
	endtask

	task automatic compare_count(input string name, input count_t expected,
			input count_t actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
			fail_run();
		end
	endtask

	task automatic drive_trace(input trace_t t, input logic valid);
		rvfi_valid     = valid;
		rvfi_insn      = t.insn;
		rvfi_trap      = t.trap;
		rvfi_rs1_addr  = t.rs1_addr;
		rvfi_rs2_addr  = t.rs2_addr;
		rvfi_rs1_rdata = t.rs1_rdata;
		rvfi_rs2_rdata = t.rs2_rdata;
		rvfi_rd_addr   = t.rd_addr;
		rvfi_rd_wdata  = t.rd_wdata;
		rvfi_pc_rdata  = t.pc_rdata;
		rvfi_pc_wdata  = t.pc_wdata;
		rvfi_mem_addr  = t.mem_addr;
		rvfi_mem_rmask = t.rmask;
		rvfi_mem_wmask = t.wmask;
		rvfi_mem_rdata = t.mem_rdata;
		rvfi_mem_wdata = t.mem_wdata;
	endtask

	task automatic wait_done(input string name);
		int cycles;
		cycles = 0;
		while (check_done !== 1'b1) begin
			if (cycles == done_timeout) begin
				$display("%s: no check_done within %0d cycles", name, done_timeout);
				fail_run();
			end else begin
				@(negedge clk);
				cycles++;
			end
		end
	endtask

	// one strobe, then the result and both counters.
	task automatic run_check(input string name, input trace_t t,
			input check_fault_t expected);
		drive_trace(t, 1'b1);
		@(negedge clk);
		drive_trace(t, 1'b0);
		wait_done(name);
		compare_fault(name, expected, check_fault);
		exp_retire = exp_retire + count_t'(1);
		if (expected != fault_none)
			exp_faults = exp_faults + count_t'(1);
		compare_count({name, " retire_count"}, exp_retire, retire_count);
		compare_count({name, " fault_count"}, exp_faults, fault_count);
	endtask

	// ########################################################################
	// directed tests.
	// ########################################################################

	task automatic check_reset();
		if (check_done !== 1'b0) begin
			$display("check_done is not low after reset");
			fail_run();
		end
		compare_fault("reset check_fault", fault_none, check_fault);
		compare_count("reset retire_count", count_t'(0), retire_count);
		compare_count("reset fault_count", count_t'(0), fault_count);
	endtask

	task automatic test_alu_ops();
		for (int round = 0; round < 3; round++) begin
			for (int i = 0; i < 8; i++) begin
				run_check($sformatf("reg_reg f3=%0d", i), alu_trace(3'(i), 1'b0, 1'b0),
					fault_none);
				run_check($sformatf("reg_imm f3=%0d", i), alu_trace(3'(i), 1'b0, 1'b1),
					fault_none);
			end
			run_check("sub", alu_trace(3'd0, 1'b1, 1'b0), fault_none);
			run_check("sra", alu_trace(3'd5, 1'b1, 1'b0), fault_none);
			run_check("srai", alu_trace(3'd5, 1'b1, 1'b1), fault_none);
			run_check("lui", lui_trace(), fault_none);
		end
	endtask

	task automatic test_bad_results();
		trace_t t;
		t = alu_trace(3'd6, 1'b0, 1'b0);
		t.rd_wdata = t.rd_wdata ^ xlen_t'(32'h0001_0000);
		run_check("bad rd_wdata", t, fault_rd_wdata);
		t = lui_trace();
		t.pc_wdata = t.pc_rdata;
		run_check("bad pc_wdata", t, fault_pc);
	endtask

	task automatic test_memory();
		trace_t t;
		run_check("lw", mem_trace(1'b0, 1'b0), fault_none);
		run_check("sw", mem_trace(1'b1, 1'b0), fault_none);
		t = mem_trace(1'b1, 1'b0);
		t.mem_wdata = t.mem_wdata ^ xlen_t'(32'h00a5_0000);
		run_check("sw bad byte", t, fault_mem_wdata);
		t = mem_trace(1'b0, 1'b0);
		t.rmask = byte_mask_t'(4'b1101);
		run_check("lw missing rmask", t, fault_mem_rmask);
	endtask

	task automatic test_traps();
		trace_t t;
		t = mem_trace(1'b0, 1'b1);
		run_check("misaligned lw", t, fault_none);
		t.trap = 1'b0;
		run_check("misaligned lw untrapped", t, fault_trap);
		t = illegal_trace();
		run_check("illegal", t, fault_none);
		t.trap = 1'b0;
		run_check("illegal untrapped", t, fault_trap);
	endtask

	task automatic test_priority();
		trace_t t;
		t = alu_trace(3'd7, 1'b0, 1'b0);
		t.rs1_addr = t.rs1_addr ^ 5'd1;
		t.rd_wdata = ~t.rd_wdata;
		run_check("rs1 before rd_wdata", t, fault_rs1);
	endtask

	// results are collected while later strobes are still being driven.
	task automatic test_back_to_back();
		trace_t       traces [4];
		check_fault_t expected [4];
		int           sent;
		int           got;
		int           cycles;
		traces[0] = alu_trace(3'd0, 1'b0, 1'b0);
		expected[0] = fault_none;
		traces[1] = alu_trace(3'd4, 1'b0, 1'b1);
		traces[1].pc_wdata = traces[1].pc_wdata + xlen_t'(8);
		expected[1] = fault_pc;
		traces[2] = mem_trace(1'b1, 1'b0);
		expected[2] = fault_none;
		traces[3] = illegal_trace();
		traces[3].trap = 1'b0;
		expected[3] = fault_trap;
		sent = 0;
		got = 0;
		cycles = 0;
		@(negedge clk);
		while (got < 4) begin
			if (check_done === 1'b1) begin
				compare_fault($sformatf("back_to_back %0d", got), expected[got], check_fault);
				got++;
			end
			if (sent < 4) begin
				drive_trace(traces[sent], 1'b1);
				sent++;
			end else begin
				drive_trace(traces[3], 1'b0);
			end
			if (cycles == done_timeout) begin
				$display("back_to_back: only %0d of 4 results arrived", got);
				fail_run();
			end else begin
				@(negedge clk);
				cycles++;
			end
		end
		exp_retire = exp_retire + count_t'(4);
		exp_faults = exp_faults + count_t'(2);
		compare_count("back_to_back retire_count", exp_retire, retire_count);
		compare_count("back_to_back fault_count", exp_faults, fault_count);
	endtask

	initial begin
		seed = 32'hc2c7;
		exp_retire = '0;
		exp_faults = '0;
		rst_n = 1'b0;
		drive_trace('0, 1'b0);
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_reset();
		test_alu_ops();
		test_bad_results();
		test_memory();
		test_traps();
		test_priority();
		test_back_to_back();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
